// ==== src/pool_pkg.sv ====
`default_nettype none

package pool_pkg;

  localparam int PIX_W = 16;
  localparam int COL_W = 7; // covers the default line depth of 120

  typedef logic [PIX_W-1:0] pixel_t;

  // one stream word, lo is the first pixel in the row
  typedef struct packed {
    pixel_t hi;
    pixel_t lo;
  } pix_pair_t;

  typedef enum logic {
    POOL_MAX = 1'b0,
    POOL_AVG = 1'b1
  } pool_mode_e;

  // horizontal partial, tagged with its position in the row
  typedef struct packed {
    pixel_t           pix;
    logic [COL_W-1:0] col;
    logic             even_row;
    logic             last_col;
  } reduced_t;

  typedef struct packed {
    pixel_t pix;
    logic   last_col;
  } pooled_t;

  // arithmetic shift by 2, one quarter of a pixel for the average
  function automatic pixel_t pix_quarter(pixel_t p);
    return pixel_t'($signed(p) >>> 2);
  endfunction

  // unsigned max or wrapping sum of two values
  function automatic pixel_t pix_combine(pool_mode_e mode, pixel_t a, pixel_t b);
    if (mode == POOL_MAX) return (a > b) ? a : b;
    return a + b;
  endfunction

endpackage

`default_nettype wire

// ==== src/pool_row_reducer.sv ====
`default_nettype none

module pool_row_reducer import pool_pkg::*; #(
  parameter int MAX_HALF_WIDTH = 120
) (
  input  wire              clk_gated,
  input  wire              rst_n,
  input  wire              pool_en_i,
  input  pool_mode_e       mode_i,
  input  wire  [COL_W-1:0] half_width_i,
  input  wire              in_valid_i,
  input  pix_pair_t        in_word_i,
  output logic             in_ready_o,
  input  wire              red_ready_i,
  output logic             red_valid_o,
  output reduced_t         red_data_o
);

  // never index past the end of the line buffer
  localparam logic [COL_W-1:0] LAST_COL_MAX = COL_W'(MAX_HALF_WIDTH - 1);

  logic [COL_W-1:0] col_q;
  logic             even_q;   // row parity, first row of a pair is odd
  logic             red_valid_q;
  reduced_t         red_data_q;

  logic   accept;
  logic   last_col;
  pixel_t lo_term;
  pixel_t hi_term;
  pixel_t pair_pix;

  assign in_ready_o = pool_en_i && (!red_valid_q || red_ready_i);
  assign accept     = in_valid_i && in_ready_o;

  assign last_col = (col_q == half_width_i - 1'b1) || (col_q == LAST_COL_MAX);

  // average works on quarters, max on the raw pixels
  always_comb begin
    if (mode_i == POOL_AVG) begin
      lo_term = pix_quarter(in_word_i.lo);
      hi_term = pix_quarter(in_word_i.hi);
    end else begin
      lo_term = in_word_i.lo;
      hi_term = in_word_i.hi;
    end
    pair_pix = pix_combine(mode_i, lo_term, hi_term);
  end

  // row position
  always_ff @(posedge clk_gated) begin
    if (!rst_n || !pool_en_i) begin
      col_q  <= '0;
      even_q <= 1'b0;
    end else if (accept) begin
      if (last_col) begin
        col_q  <= '0;
        even_q <= !even_q;   // next row of the pair
      end else begin
        col_q <= col_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_gated) begin
    if (!rst_n) begin
      red_valid_q <= 1'b0;
    end else if (accept) begin
      red_valid_q <= 1'b1;
    end else if (red_ready_i) begin
      red_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_gated) begin
    if (accept) begin
      red_data_q.pix      <= pair_pix;
      red_data_q.col      <= col_q;
      red_data_q.even_row <= even_q;
      red_data_q.last_col <= last_col;
    end
  end

  assign red_valid_o = red_valid_q;
  assign red_data_o  = red_data_q;

endmodule

`default_nettype wire

// ==== src/pool_line_buffer.sv ====
`default_nettype none

module pool_line_buffer import pool_pkg::*; #(
  parameter int MAX_HALF_WIDTH = 120
) (
  input  wire        clk_gated,
  input  wire        rst_n,
  input  pool_mode_e mode_i,
  input  wire        red_valid_i,
  input  reduced_t   red_data_i,
  output logic       red_ready_o,
  input  wire        pool_ready_i,
  output logic       pool_valid_o,
  output pooled_t    pool_data_o
);

  // one partial per column of the odd row
  pixel_t line_mem [MAX_HALF_WIDTH];

  logic    pool_valid_q;
  pooled_t pool_data_q;

  logic   take;
  logic   take_even;
  logic   take_odd;
  pixel_t stored_pix;
  pixel_t vert_pix;

  // odd-row items only touch the memory, so they never wait
  assign red_ready_o = !red_data_i.even_row || !pool_valid_q || pool_ready_i;

  assign take      = red_valid_i && red_ready_o;
  assign take_even = take && red_data_i.even_row;
  assign take_odd  = take && !red_data_i.even_row;

  assign stored_pix = line_mem[red_data_i.col];   // written during the previous row
  assign vert_pix   = pix_combine(mode_i, stored_pix, red_data_i.pix);

  always_ff @(posedge clk_gated) begin
    if (take_odd) begin
      line_mem[red_data_i.col] <= red_data_i.pix;
    end
  end

  always_ff @(posedge clk_gated) begin
    if (!rst_n) begin
      pool_valid_q <= 1'b0;
    end else if (take_even) begin
      pool_valid_q <= 1'b1;
    end else if (pool_ready_i) begin
      pool_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_gated) begin
    if (take_even) begin
      pool_data_q.pix      <= vert_pix;
      pool_data_q.last_col <= red_data_i.last_col;
    end
  end

  assign pool_valid_o = pool_valid_q;
  assign pool_data_o  = pool_data_q;

endmodule

`default_nettype wire

// ==== src/pool_out_packer.sv ====
`default_nettype none

module pool_out_packer import pool_pkg::*; (
  input  wire       clk_gated,
  input  wire       rst_n,
  input  wire       pool_valid_i,
  input  pooled_t   pool_data_i,
  output logic      pool_ready_o,
  input  wire       out_ready_i,
  output logic      out_valid_o,
  output pix_pair_t out_word_o
);

  logic      half_q;   // lo_q holds the first pixel of a word
  pixel_t    lo_q;
  logic      out_valid_q;
  pix_pair_t out_word_q;

  logic take;
  logic word_done;

  assign pool_ready_o = !out_valid_q || out_ready_i;
  assign take         = pool_valid_i && pool_ready_o;

  // second pixel, or a lone first pixel at the end of the row
  assign word_done = take && (half_q || pool_data_i.last_col);

  always_ff @(posedge clk_gated) begin
    if (!rst_n) begin
      half_q <= 1'b0;
    end else if (take) begin
      half_q <= !half_q && !pool_data_i.last_col;
    end
  end

  always_ff @(posedge clk_gated) begin
    if (take && !half_q) begin
      lo_q <= pool_data_i.pix;
    end
  end

  always_ff @(posedge clk_gated) begin
    if (!rst_n) begin
      out_valid_q <= 1'b0;
    end else if (word_done) begin
      out_valid_q <= 1'b1;
    end else if (out_ready_i) begin
      out_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_gated) begin
    if (word_done) begin
      if (half_q) begin
        out_word_q.lo <= lo_q;
        out_word_q.hi <= pool_data_i.pix;
      end else begin
        out_word_q.lo <= pool_data_i.pix;
        out_word_q.hi <= '0;   // odd half width, no partner pixel
      end
    end
  end

  assign out_valid_o = out_valid_q;
  assign out_word_o  = out_word_q;

endmodule

`default_nettype wire

// ==== src/pool2x2_top.sv ====
`default_nettype none

module pool2x2_top import pool_pkg::*; #(
  parameter int MAX_HALF_WIDTH = 120
) (
  input  wire              clk_gated,
  input  wire              rst_n,
  input  wire              pool_en_i,
  input  pool_mode_e       mode_i,
  input  wire  [COL_W-1:0] half_width_i,
  input  wire              in_valid_i,
  input  pix_pair_t        in_word_i,
  output logic             in_ready_o,
  input  wire              out_ready_i,
  output logic             out_valid_o,
  output pix_pair_t        out_word_o
);

  logic     red_valid;
  logic     red_ready;
  reduced_t red_data;

  logic     pool_valid;
  logic     pool_ready;
  pooled_t  pool_data;

  // horizontal pair reduction
  pool_row_reducer #(
    .MAX_HALF_WIDTH (MAX_HALF_WIDTH)
  ) u_reducer (
    .clk_gated    (clk_gated),
    .rst_n        (rst_n),
    .pool_en_i    (pool_en_i),
    .mode_i       (mode_i),
    .half_width_i (half_width_i),
    .in_valid_i   (in_valid_i),
    .in_word_i    (in_word_i),
    .in_ready_o   (in_ready_o),
    .red_ready_i  (red_ready),
    .red_valid_o  (red_valid),
    .red_data_o   (red_data)
  );

  // vertical combine across the row pair
  pool_line_buffer #(
    .MAX_HALF_WIDTH (MAX_HALF_WIDTH)
  ) u_line_buf (
    .clk_gated    (clk_gated),
    .rst_n        (rst_n),
    .mode_i       (mode_i),
    .red_valid_i  (red_valid),
    .red_data_i   (red_data),
    .red_ready_o  (red_ready),
    .pool_ready_i (pool_ready),
    .pool_valid_o (pool_valid),
    .pool_data_o  (pool_data)
  );

  pool_out_packer u_packer (
    .clk_gated    (clk_gated),
    .rst_n        (rst_n),
    .pool_valid_i (pool_valid),
    .pool_data_i  (pool_data),
    .pool_ready_o (pool_ready),
    .out_ready_i  (out_ready_i),
    .out_valid_o  (out_valid_o),
    .out_word_o   (out_word_o)
  );

endmodule

`default_nettype wire

// ==== dv/pool_ref_model.svh ====
`ifndef POOL_REF_MODEL_SVH
`define POOL_REF_MODEL_SVH

// quarter of a pixel, sign bits shifted in from the top
function automatic pixel_t quarter_of(pixel_t p);
  return {{2{p[PIX_W-1]}}, p[PIX_W-1:2]};
endfunction

function automatic pixel_t larger_of(pixel_t a, pixel_t b);
  return (a > b) ? a : b;   // unsigned compare
endfunction

// one pooled pixel from the four pixels of a 2x2 block
function automatic pixel_t pool_four(pool_mode_e mode, pixel_t a, pixel_t b,
                                     pixel_t c, pixel_t d);
  pixel_t sum;
  if (mode == POOL_MAX) begin
    return larger_of(larger_of(a, b), larger_of(c, d));
  end
  sum = quarter_of(a) + quarter_of(b) + quarter_of(c) + quarter_of(d);   // wraps at 16 bits
  return sum;
endfunction

// expected output words for the image in img, pushed in output order
task automatic model_image(pool_mode_e mode, int hw, int rows);
  pix_pair_t top;
  pix_pair_t bot;
  pix_pair_t word;
  pixel_t    pix;
  pixel_t    first;
  int        p;
  int        c;
  first = '0;
  // a trailing odd row has no partner and gives no output
  for (p = 0; p < rows / 2; p++) begin
    for (c = 0; c < hw; c++) begin
      top = img[2 * p * hw + c];
      bot = img[(2 * p + 1) * hw + c];
      pix = pool_four(mode, top.lo, top.hi, bot.lo, bot.hi);
      if (c % 2 == 0) begin
        first = pix;
        if (c == hw - 1) begin
          word.lo = pix;
          word.hi = '0;   // odd half width
          exp_q.push_back(word);
        end
      end else begin
        word.lo = first;
        word.hi = pix;
        exp_q.push_back(word);
      end
    end
  end
endtask

`endif

// ==== dv/tb_pool2x2.sv ====
`default_nettype none

module tb_pool2x2 import pool_pkg::*; ();

  localparam int CLK_PERIOD = 4;
  // input words over all images, sizes the watchdog
  localparam int TOTAL_WORDS = 6 * 4 + 4 * 4 + 5 * 4 + 7 * 6 + 4 * 3 + 4 * 2;
  localparam int WATCHDOG_CYCLES = TOTAL_WORDS * 20 + 200;

  logic             clk_gated = 1'b0;
  logic             rst_n = 1'b0;
  logic             pool_en_i = 1'b0;
  pool_mode_e       mode_i = POOL_MAX;
  logic [COL_W-1:0] half_width_i = '0;
  logic             in_valid_i = 1'b0;
  pix_pair_t        in_word_i = '0;
  logic             in_ready_o;
  logic             out_ready_i = 1'b1;
  logic             out_valid_o;
  pix_pair_t        out_word_o;

  pix_pair_t img[$];     // current image, row by row
  pix_pair_t exp_q[$];   // expected output words, oldest first
  pix_pair_t exp_head = '0;
  logic      exp_avail = 1'b0;
  logic      bp_en = 1'b0;   // random out_ready_i while set

  int err_count = 0;
  int acc_count = 0;    // input transfers
  int xfer_count = 0;   // output transfers
  int pop_count = 0;

  `include "pool_ref_model.svh"

  always #(CLK_PERIOD / 2) clk_gated = !clk_gated;

  pool2x2_top DUT (
    .clk_gated    (clk_gated),
    .rst_n        (rst_n),
    .pool_en_i    (pool_en_i),
    .mode_i       (mode_i),
    .half_width_i (half_width_i),
    .in_valid_i   (in_valid_i),
    .in_word_i    (in_word_i),
    .in_ready_o   (in_ready_o),
    .out_ready_i  (out_ready_i),
    .out_valid_o  (out_valid_o),
    .out_word_o   (out_word_o)
  );

  always @(posedge clk_gated) begin
    if (rst_n && in_valid_i && in_ready_o) acc_count <= acc_count + 1;
    if (rst_n && out_valid_o && out_ready_i) xfer_count <= xfer_count + 1;
  end

  // retire one expected word per output transfer
  always @(negedge clk_gated) begin
    if (pop_count < xfer_count) begin
      if (exp_q.size() != 0) void'(exp_q.pop_front());
      pop_count = pop_count + 1;
    end
    exp_avail = (exp_q.size() != 0);
    exp_head  = exp_avail ? exp_q[0] : '0;
  end

  always @(negedge clk_gated) begin
    if (bp_en) out_ready_i = (($urandom % 3) != 0);   // ready two cycles in three
    else out_ready_i = 1'b1;
  end

  assert property (@(posedge clk_gated) $past(!rst_n) |-> !out_valid_o)
    else begin
      err_count = err_count + 1;
      $display("MISMATCH out_valid_o got %h expected 0 after reset", $sampled(out_valid_o));
    end

  assert property (@(posedge clk_gated) !pool_en_i |-> !in_ready_o)
    else begin
      err_count = err_count + 1;
      $display("MISMATCH in_ready_o got %h expected 0 while disabled", $sampled(in_ready_o));
    end

  assert property (@(posedge clk_gated) disable iff (!rst_n)
    (out_valid_o && out_ready_i) |-> exp_avail)
    else begin
      err_count = err_count + 1;
      $display("output word %h was transferred with no word expected", $sampled(out_word_o));
    end

  // every transferred word is the oldest expected one
  assert property (@(posedge clk_gated) disable iff (!rst_n)
    (out_valid_o && out_ready_i && exp_avail) |-> (out_word_o == exp_head))
    else begin
      err_count = err_count + 1;
      $display("MISMATCH out_word_o got %h expected %h", $sampled(out_word_o),
               $sampled(exp_head));
    end

  assert property (@(posedge clk_gated) disable iff (!rst_n)
    $past(out_valid_o && !out_ready_i) |-> (out_valid_o && $stable(out_word_o)))
    else begin
      err_count = err_count + 1;
      $display("MISMATCH stalled output moved, out_valid_o %h out_word_o %h",
               $sampled(out_valid_o), $sampled(out_word_o));
    end

  // random pixels, sign and range edges at the start of each image
  task automatic fill_image(int n_words);
    pix_pair_t w;
    int        i;
    img.delete();
    for (i = 0; i < n_words; i++) begin
      w = $urandom;
      if (i == 0) w = {16'h8000, 16'hffff};
      if (i == 1) w = {16'h7fff, 16'hfffd};
      img.push_back(w);
    end
  endtask

  task automatic drive_image(int n_words, bit gaps);
    int start;
    int done;
    int shown;   // index of the word on the bus
    int cyc;
    start = acc_count;
    done  = 0;
    shown = -1;
    cyc   = 0;
    while (done < n_words) begin
      @(negedge clk_gated);
      done = acc_count - start;
      cyc  = cyc + 1;
      if (done >= n_words) begin
        in_valid_i = 1'b0;
      end else if (!in_valid_i || shown != done) begin   // a word still waiting is held
        if (gaps && (cyc % 4 == 3)) begin
          in_valid_i = 1'b0;
        end else begin
          in_valid_i = 1'b1;
          in_word_i  = img[done];
          shown      = done;
        end
      end
    end
  endtask

  task automatic run_image(pool_mode_e mode, int hw, int rows, bit bp, bit gaps);
    @(posedge clk_gated);
    fill_image(hw * rows);
    model_image(mode, hw, rows);
    bp_en = bp;
    @(negedge clk_gated);
    mode_i       = mode;
    half_width_i = COL_W'(hw);
    pool_en_i    = 1'b1;
    drive_image(hw * rows, gaps);
    while (exp_q.size() != 0) @(posedge clk_gated);
    // odd-row items reach the buffer one cycle after their transfer
    repeat (2) @(negedge clk_gated);
    pool_en_i = 1'b0;
    @(posedge clk_gated);
    bp_en = 1'b0;
  endtask

  initial begin
    void'($urandom(32'ha004));
    repeat (4) @(negedge clk_gated);
    rst_n = 1'b1;
    repeat (3) @(negedge clk_gated);   // idle, pipeline disabled
    run_image(POOL_MAX, 6, 4, 1'b0, 1'b0);
    run_image(POOL_AVG, 4, 4, 1'b0, 1'b0);
    run_image(POOL_MAX, 5, 4, 1'b0, 1'b0);
    run_image(POOL_AVG, 7, 6, 1'b1, 1'b1);
    // dangling odd row, then a fresh image with the other method
    run_image(POOL_MAX, 4, 3, 1'b0, 1'b0);
    run_image(POOL_AVG, 4, 2, 1'b1, 1'b0);
    @(negedge clk_gated);
    $display("run complete, %0d words checked, %0d errors", xfer_count, err_count);
    if (err_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_gated);
    $display("run timed out after %0d cycles, %0d errors", WATCHDOG_CYCLES, err_count);
    $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== pool2x2.f ====
+incdir+dv
src/pool_pkg.sv
src/pool_row_reducer.sv
src/pool_line_buffer.sv
src/pool_out_packer.sv
src/pool2x2_top.sv
dv/tb_pool2x2.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f pool2x2.f --top-module tb_pool2x2 -Mdir obj_dir \
  || { echo "build failed"; exit 1; }

sim_out=$(./obj_dir/Vtb_pool2x2)
printf '%s\n' "$sim_out"
printf '%s\n' "$sim_out" | grep -qx "TB PASSED" && exit 0 || exit 1
